// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: design/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and register file sizes
`define WORD_W 16
`define REG_N 4
`define REG_AW 2

// opcodes, instruction bits [15:12]
`define OP_ADI 4'd4
`define OP_LWD 4'd7
`define OP_SWD 4'd8
`define OP_RTYPE 4'd15

// function codes for OP_RTYPE, bits [5:0]
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_WWD 6'd28
`define FN_HLT 6'd29

// first fetch address after reset
`define RESET_PC 16'h0000

`endif

// File: design/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_AW-1:0] reg_idx_t;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR
	} alu_op_t;

	// operand source for the instruction in EX
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	// decoded control, all zero for a bubble
	typedef struct packed {
		alu_op_t alu_op;
		logic imm_sel;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic wwd;
		logic halt;
		logic valid;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t inst;
		logic valid;
	} if_id_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t rs_val;
		word_t rt_val;
		word_t imm;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dst;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_result;
		word_t store_data;
		reg_idx_t dst;
	} ex_mem_t;

	// value is already the load data or the alu result
	typedef struct packed {
		ctrl_t ctrl;
		word_t value;
		reg_idx_t dst;
	} mem_wb_t;

	typedef struct packed {
		logic rd;
		logic wr;
		word_t addr;
		word_t wdata;
	} dmem_req_t;

endpackage

// File: design/cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	output logic      imem_rd_o,
	output word_t     imem_addr_o,
	input  word_t     imem_data_i,
	output dmem_req_t dmem_req_o,
	input  word_t     dmem_rdata_i,
	output word_t     num_inst_o,
	output word_t     output_port_o,
	output logic      is_halted_o
);

	if_id_t   if_id;
	ctrl_t    ctrl;
	reg_idx_t rs, rt, dst;
	reg_idx_t ex_dst, mem_dst, wb_idx;
	word_t    imm, rs_data, rt_data;
	word_t    mem_fwd, wb_fwd, wb_data;
	logic     stall, bubble, fetch_stop;
	logic     ex_mem_read, mem_reg_write, wb_en;
	fwd_sel_t fwd_a, fwd_b;
	ex_mem_t  ex_mem;

	pipe_control u_ctrl (
		.clk(clk), .reset_n(reset_n), .if_id_i(if_id),
		.ex_dst_i(ex_dst), .ex_mem_read_i(ex_mem_read),
		.mem_dst_i(mem_dst), .mem_reg_write_i(mem_reg_write),
		.wb_dst_i(wb_idx), .wb_reg_write_i(wb_en),
		.ctrl_o(ctrl), .rs_o(rs), .rt_o(rt), .dst_o(dst), .imm_o(imm),
		.stall_o(stall), .bubble_o(bubble), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b),
		.fetch_stop_o(fetch_stop)
	);

	fetch_stage u_fetch (
		.clk(clk), .reset_n(reset_n), .stall_i(stall), .stop_i(fetch_stop),
		.imem_data_i(imem_data_i), .imem_rd_o(imem_rd_o), .imem_addr_o(imem_addr_o),
		.if_id_o(if_id)
	);

	register_file u_regs (
		.clk(clk), .reset_n(reset_n), .rs_i(rs), .rt_i(rt),
		.wr_en_i(wb_en), .wr_idx_i(wb_idx), .wr_data_i(wb_data),
		.rs_data_o(rs_data), .rt_data_o(rt_data)
	);

	execute_stage u_exec (
		.clk(clk), .reset_n(reset_n), .ctrl_i(ctrl),
		.rs_i(rs), .rt_i(rt), .dst_i(dst), .imm_i(imm),
		.rs_data_i(rs_data), .rt_data_i(rt_data), .bubble_i(bubble),
		.fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .mem_fwd_i(mem_fwd), .wb_fwd_i(wb_fwd),
		.ex_mem_o(ex_mem), .ex_dst_o(ex_dst), .ex_mem_read_o(ex_mem_read)
	);

	mem_wb_stage u_memwb (
		.clk(clk), .reset_n(reset_n), .ex_mem_i(ex_mem), .dmem_rdata_i(dmem_rdata_i),
		.dmem_req_o(dmem_req_o), .mem_fwd_o(mem_fwd), .wb_fwd_o(wb_fwd),
		.mem_dst_o(mem_dst), .mem_reg_write_o(mem_reg_write),
		.wb_idx_o(wb_idx), .wb_en_o(wb_en), .wb_data_o(wb_data),
		.num_inst_o(num_inst_o), .output_port_o(output_port_o),
		.is_halted_o(is_halted_o)
	);

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  ctrl_t    ctrl_i,
	input  reg_idx_t rs_i,
	input  reg_idx_t rt_i,
	input  reg_idx_t dst_i,
	input  word_t    imm_i,
	input  word_t    rs_data_i,
	input  word_t    rt_data_i,
	input  logic     bubble_i,
	input  fwd_sel_t fwd_a_i,
	input  fwd_sel_t fwd_b_i,
	input  word_t    mem_fwd_i,
	input  word_t    wb_fwd_i,
	output ex_mem_t  ex_mem_o,
	output reg_idx_t ex_dst_o,
	output logic     ex_mem_read_o
);

	id_ex_t  id_ex_q;
	ex_mem_t ex_mem_q;
	word_t   op_a, op_b, alu_b, alu_y;

	function automatic word_t pick(input fwd_sel_t sel, input word_t reg_val,
		input word_t mem_val, input word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		id_ex_q <= '{ctrl: bubble_i ? '0 : ctrl_i, rs_val: rs_data_i, rt_val: rt_data_i,
			imm: imm_i, rs: rs_i, rt: rt_i, dst: dst_i};
		if (!reset_n) begin
			id_ex_q.ctrl <= '0;
		end
	end

	assign op_a  = pick(fwd_a_i, id_ex_q.rs_val, mem_fwd_i, wb_fwd_i);
	assign op_b  = pick(fwd_b_i, id_ex_q.rt_val, mem_fwd_i, wb_fwd_i);
	assign alu_b = id_ex_q.ctrl.imm_sel ? id_ex_q.imm : op_b;

	always_comb begin
		case (id_ex_q.ctrl.alu_op)
			ALU_SUB: alu_y = op_a - alu_b;
			ALU_AND: alu_y = op_a & alu_b;
			ALU_OR:  alu_y = op_a | alu_b;
			default: alu_y = op_a + alu_b;
		endcase
	end

	// store data is the forwarded rt value
	always_ff @(posedge clk) begin
		ex_mem_q <= '{ctrl: id_ex_q.ctrl, alu_result: alu_y, store_data: op_b,
			dst: id_ex_q.dst};
		if (!reset_n) begin
			ex_mem_q.ctrl <= '0;
		end
	end

	assign ex_mem_o      = ex_mem_q;
	assign ex_dst_o      = id_ex_q.dst;
	assign ex_mem_read_o = id_ex_q.ctrl.mem_read;

	// an empty slot in EX never writes a register or memory
	assert property (@(posedge clk) disable iff (!reset_n)
		!id_ex_q.ctrl.valid |-> !(id_ex_q.ctrl.reg_write || id_ex_q.ctrl.mem_write))
		else $error("bubble carried a register or memory write");

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module fetch_stage import cpu_pkg::*; (
	input  logic   clk,
	input  logic   reset_n,
	input  logic   stall_i,
	input  logic   stop_i,
	input  word_t  imem_data_i,
	output logic   imem_rd_o,
	output word_t  imem_addr_o,
	output if_id_t if_id_o
);

	word_t  pc_q;
	logic   run_q;
	if_id_t if_id_q;

	// first fetch one cycle after reset is released
	assign imem_rd_o   = run_q && !stop_i;
	assign imem_addr_o = pc_q;
	assign if_id_o     = if_id_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc_q  <= `RESET_PC;
			run_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (imem_rd_o && !stall_i) begin
				pc_q <= pc_q + 1'b1;
			end
		end
	end

	// IF/ID holds during a load-use stall
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			if_id_q.pc   <= pc_q;
			if_id_q.inst <= imem_data_i;
		end
		if (!reset_n) begin
			if_id_q.valid <= 1'b0;
		end else if (!stall_i) begin
			if_id_q.valid <= imem_rd_o;
		end
	end

endmodule

// File: design/mem_wb_stage.sv
`timescale 1ns/1ns

module mem_wb_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  ex_mem_t   ex_mem_i,
	input  word_t     dmem_rdata_i,
	output dmem_req_t dmem_req_o,
	output word_t     mem_fwd_o,
	output word_t     wb_fwd_o,
	output reg_idx_t  mem_dst_o,
	output logic      mem_reg_write_o,
	output reg_idx_t  wb_idx_o,
	output logic      wb_en_o,
	output word_t     wb_data_o,
	output word_t     num_inst_o,
	output word_t     output_port_o,
	output logic      is_halted_o
);

	mem_wb_t mem_wb_q;
	word_t   num_inst_q, port_q;
	logic    halted_q;

	// address is the alu result of rs + imm
	assign dmem_req_o.rd    = ex_mem_i.ctrl.mem_read;
	assign dmem_req_o.wr    = ex_mem_i.ctrl.mem_write;
	assign dmem_req_o.addr  = ex_mem_i.alu_result;
	assign dmem_req_o.wdata = ex_mem_i.store_data;

	assign mem_fwd_o       = ex_mem_i.alu_result;
	assign mem_dst_o       = ex_mem_i.dst;
	assign mem_reg_write_o = ex_mem_i.ctrl.reg_write;

	always_ff @(posedge clk) begin
		mem_wb_q <= '{ctrl: ex_mem_i.ctrl, dst: ex_mem_i.dst,
			value: ex_mem_i.ctrl.mem_read ? dmem_rdata_i : ex_mem_i.alu_result};
		if (!reset_n) begin
			mem_wb_q.ctrl <= '0;
		end
	end

	assign wb_fwd_o  = mem_wb_q.value;
	assign wb_idx_o  = mem_wb_q.dst;
	assign wb_en_o   = mem_wb_q.ctrl.reg_write;
	assign wb_data_o = mem_wb_q.value;

	// retire side effects
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_inst_q <= '0;
			port_q     <= '0;
			halted_q   <= 1'b0;
		end else begin
			if (mem_wb_q.ctrl.valid) begin
				num_inst_q <= num_inst_q + 1'b1;
			end
			if (mem_wb_q.ctrl.wwd) begin
				port_q <= mem_wb_q.value;
			end
			if (mem_wb_q.ctrl.halt) begin
				halted_q <= 1'b1;
			end
		end
	end

	assign num_inst_o    = num_inst_q;
	assign output_port_o = port_q;
	assign is_halted_o   = halted_q;

	// decode never sets both, the RAM has no defined answer to it
	assert property (@(posedge clk) disable iff (!reset_n) !(dmem_req_o.rd && dmem_req_o.wr))
		else $error("data memory read and write strobes high together");

endmodule

// File: design/pipe_control.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module pipe_control import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  if_id_t   if_id_i,
	input  reg_idx_t ex_dst_i,
	input  logic     ex_mem_read_i,
	input  reg_idx_t mem_dst_i,
	input  logic     mem_reg_write_i,
	input  reg_idx_t wb_dst_i,
	input  logic     wb_reg_write_i,
	output ctrl_t    ctrl_o,
	output reg_idx_t rs_o,
	output reg_idx_t rt_o,
	output reg_idx_t dst_o,
	output word_t    imm_o,
	output logic     stall_o,
	output logic     bubble_o,
	output fwd_sel_t fwd_a_o,
	output fwd_sel_t fwd_b_o,
	output logic     fetch_stop_o
);

	logic [3:0] opcode;
	logic [5:0] funct;
	logic       uses_rs, uses_rt, load_use, stop_q;
	reg_idx_t   rd, rs_ex_q, rt_ex_q;

	assign opcode = if_id_i.inst[15:12];
	assign funct  = if_id_i.inst[5:0];
	assign rs_o   = if_id_i.inst[11:10];
	assign rt_o   = if_id_i.inst[9:8];
	assign rd     = if_id_i.inst[7:6];

	always_comb begin
		ctrl_o  = '0;
		uses_rs = 1'b1;
		uses_rt = 1'b0;
		dst_o   = rt_o;
		imm_o   = {{(`WORD_W-8){if_id_i.inst[7]}}, if_id_i.inst[7:0]};
		case (opcode)
			`OP_RTYPE: begin
				// rd and funct share the imm bits, wwd passes rs through rs + 0
				dst_o = rd;
				imm_o = '0;
				case (funct)
					`FN_ADD: {ctrl_o.alu_op, ctrl_o.reg_write, uses_rt} = {ALU_ADD, 2'b11};
					`FN_SUB: {ctrl_o.alu_op, ctrl_o.reg_write, uses_rt} = {ALU_SUB, 2'b11};
					`FN_AND: {ctrl_o.alu_op, ctrl_o.reg_write, uses_rt} = {ALU_AND, 2'b11};
					`FN_ORR: {ctrl_o.alu_op, ctrl_o.reg_write, uses_rt} = {ALU_OR, 2'b11};
					`FN_WWD: {ctrl_o.imm_sel, ctrl_o.wwd} = 2'b11;
					`FN_HLT: {ctrl_o.halt, uses_rs} = 2'b10;
					default: uses_rs = 1'b0;
				endcase
			end
			`OP_ADI: {ctrl_o.imm_sel, ctrl_o.reg_write} = 2'b11;
			`OP_LWD: {ctrl_o.imm_sel, ctrl_o.reg_write, ctrl_o.mem_read} = 3'b111;
			`OP_SWD: {ctrl_o.imm_sel, ctrl_o.mem_write, uses_rt} = 3'b111;
			default: uses_rs = 1'b0;
		endcase
		ctrl_o.valid = 1'b1;
		if (!if_id_i.valid) begin
			ctrl_o = '0;
		end
	end

	// load in EX whose result the decoding instruction needs
	assign load_use = ctrl_o.valid && ex_mem_read_i &&
		((uses_rs && rs_o == ex_dst_i) || (uses_rt && rt_o == ex_dst_i));
	assign stall_o  = load_use;
	assign bubble_o = load_use;

	// stop takes effect in the decode cycle so the next word is dropped
	assign fetch_stop_o = stop_q || ctrl_o.halt;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			stop_q <= 1'b0;
		end else if (ctrl_o.halt) begin
			stop_q <= 1'b1;
		end
	end

	// source indices of the instruction now entering EX
	always_ff @(posedge clk) begin
		rs_ex_q <= rs_o;
		rt_ex_q <= rt_o;
	end

	// EX/MEM wins over MEM/WB
	assign fwd_a_o = (mem_reg_write_i && mem_dst_i == rs_ex_q) ? FWD_MEM :
		(wb_reg_write_i && wb_dst_i == rs_ex_q) ? FWD_WB : FWD_REG;
	assign fwd_b_o = (mem_reg_write_i && mem_dst_i == rt_ex_q) ? FWD_MEM :
		(wb_reg_write_i && wb_dst_i == rt_ex_q) ? FWD_WB : FWD_REG;

	// the bubble behind a load leaves nothing to stall on
	assert property (@(posedge clk) disable iff (!reset_n) stall_o |=> !stall_o)
		else $error("load-use stall lasted more than one cycle");

endmodule

// File: design/register_file.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module register_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  reg_idx_t rs_i,
	input  reg_idx_t rt_i,
	input  logic     wr_en_i,
	input  reg_idx_t wr_idx_i,
	input  word_t    wr_data_i,
	output word_t    rs_data_o,
	output word_t    rt_data_o
);

	word_t regs [`REG_N];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i) begin
			regs[wr_idx_i] <= wr_data_i;
		end
	end

	// write-back in the same cycle is visible to decode
	assign rs_data_o = (wr_en_i && wr_idx_i == rs_i) ? wr_data_i : regs[rs_i];
	assign rt_data_o = (wr_en_i && wr_idx_i == rt_i) ? wr_data_i : regs[rt_i];

endmodule

// File: dv/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_tb import cpu_pkg::*; ();

	localparam int PROG_LEN  = 60;
	localparam int TIMEOUT   = 2 * PROG_LEN + 40;
	localparam int RAM_WORDS = 16;

	logic      clk, reset_n;
	logic      imem_rd, halted;
	word_t     imem_addr, imem_data, dmem_rdata, num_inst, out_port;
	dmem_req_t dmem_req;

	// reference model state and expected traces
	word_t model_regs [`REG_N];
	word_t model_ram [RAM_WORDS];
	word_t model_port;
	word_t exp_wwd [$];
	word_t exp_st_addr [$];
	word_t exp_st_data [$];
	int    exp_count;
	int    prog_len;

	word_t prev_port, exp_val;
	int    cycles;

	tb_clock #(.PERIOD_NS(40)) u_clk (.clk_o(clk));

	tb_memory u_mem (
		.clk(clk), .imem_rd_i(imem_rd), .imem_addr_i(imem_addr), .imem_data_o(imem_data),
		.dmem_req_i(dmem_req), .dmem_rdata_o(dmem_rdata)
	);

	cpu_top cpu_top_i (
		.clk(clk), .reset_n(reset_n),
		.imem_rd_o(imem_rd), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
		.dmem_req_o(dmem_req), .dmem_rdata_i(dmem_rdata),
		.num_inst_o(num_inst), .output_port_o(out_port), .is_halted_o(halted)
	);

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic value_fail(input string name, input word_t exp, input word_t act);
		$display("Fail %s expected %h actual %h", name, exp, act);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic word_t rtype(input logic [5:0] fn, input int rs, input int rt,
		input int rd);
		return {`OP_RTYPE, rs[1:0], rt[1:0], rd[1:0], fn};
	endfunction

	function automatic word_t itype(input logic [3:0] op, input int rs, input int rt,
		input int imm);
		return {op, rs[1:0], rt[1:0], imm[7:0]};
	endfunction

	// ISA semantics of one instruction in zero time
	task automatic execute(input word_t inst);
		word_t a, b, imm, addr;
		a    = model_regs[inst[11:10]];
		b    = model_regs[inst[9:8]];
		imm  = {{8{inst[7]}}, inst[7:0]};
		addr = a + imm;
		case (inst[15:12])
			`OP_RTYPE: begin
				case (inst[5:0])
					`FN_ADD: model_regs[inst[7:6]] = a + b;
					`FN_SUB: model_regs[inst[7:6]] = a - b;
					`FN_AND: model_regs[inst[7:6]] = a & b;
					`FN_ORR: model_regs[inst[7:6]] = a | b;
					`FN_WWD: begin
						// the port is only seen to change
						if (a != model_port) begin
							exp_wwd.push_back(a);
							model_port = a;
						end
					end
					default: ;
				endcase
			end
			`OP_ADI: model_regs[inst[9:8]] = addr;
			`OP_LWD: model_regs[inst[9:8]] = model_ram[addr[3:0]];
			`OP_SWD: begin
				exp_st_addr.push_back(addr);
				exp_st_data.push_back(b);
				model_ram[addr[3:0]] = b;
			end
			default: ;
		endcase
		exp_count++;
	endtask

	task automatic emit(input word_t inst);
		u_mem.load_rom(prog_len, inst);
		execute(inst);
		prog_len++;
	endtask

	task automatic build_program();
		int kind, r;
		while (prog_len < PROG_LEN - 1) begin
			if (prog_len % 10 == 0) begin
				// load then a direct consumer of its destination
				r = $urandom_range(0, 3);
				emit(itype(`OP_LWD, $urandom_range(0, 3), r, $urandom_range(0, 15)));
				if ($urandom_range(0, 1) == 1) begin
					emit(rtype(`FN_ADD, r, $urandom_range(0, 3), $urandom_range(0, 3)));
				end else begin
					emit(rtype(`FN_WWD, r, 0, 0));
				end
			end else begin
				kind = $urandom_range(0, 9);
				case (kind)
					0: emit(rtype(`FN_ADD, $urandom_range(0, 3), $urandom_range(0, 3),
						$urandom_range(0, 3)));
					1: emit(rtype(`FN_SUB, $urandom_range(0, 3), $urandom_range(0, 3),
						$urandom_range(0, 3)));
					2: emit(rtype(`FN_AND, $urandom_range(0, 3), $urandom_range(0, 3),
						$urandom_range(0, 3)));
					3: emit(rtype(`FN_ORR, $urandom_range(0, 3), $urandom_range(0, 3),
						$urandom_range(0, 3)));
					4: emit(itype(`OP_ADI, $urandom_range(0, 3), $urandom_range(0, 3),
						$urandom_range(0, 255)));
					5: emit(itype(`OP_LWD, $urandom_range(0, 3), $urandom_range(0, 3),
						$urandom_range(0, 15)));
					6: emit(itype(`OP_SWD, $urandom_range(0, 3), $urandom_range(0, 3),
						$urandom_range(0, 15)));
					default: emit(rtype(`FN_WWD, $urandom_range(0, 3), 0, 0));
				endcase
			end
		end
		emit(rtype(`FN_HLT, 0, 0, 0));
	endtask

	// reset state while reset is low and one cycle after
	assert property (@(posedge clk) !reset_n |=>
		(!halted && !imem_rd && imem_addr == `RESET_PC && !dmem_req.rd && !dmem_req.wr &&
		num_inst == '0 && out_port == '0))
		else report_fail("outputs not in reset state");

	assert property (@(posedge clk) disable iff (!reset_n)
		num_inst == $past(num_inst) || num_inst == $past(num_inst) + 16'd1)
		else report_fail("instruction counter jumped by more than one");

	assert property (@(posedge clk) disable iff (!reset_n)
		halted |=> halted && $stable(out_port) && $stable(num_inst))
		else report_fail("halt dropped or outputs changed after halt");

	assert property (@(posedge clk) disable iff (!reset_n)
		halted |-> !imem_rd && !dmem_req.rd && !dmem_req.wr)
		else report_fail("memory strobe seen after halt");

	// outputs move only at the rising edge and are checked mid-cycle
	always @(negedge clk) begin
		if (out_port != prev_port) begin
			assert (exp_wwd.size() > 0)
				else report_fail("output port changed with no WWD value left");
			exp_val = exp_wwd.pop_front();
			assert (out_port == exp_val) else value_fail("wwd", exp_val, out_port);
		end
		prev_port = out_port;
		if (dmem_req.wr) begin
			assert (exp_st_addr.size() > 0) else report_fail("unexpected store");
			exp_val = exp_st_addr.pop_front();
			assert (dmem_req.addr == exp_val) else value_fail("store_addr", exp_val,
				dmem_req.addr);
			exp_val = exp_st_data.pop_front();
			assert (dmem_req.wdata == exp_val) else value_fail("store_data", exp_val,
				dmem_req.wdata);
		end
	end

	initial begin
		reset_n    = 1'b0;
		prog_len   = 0;
		exp_count  = 0;
		model_port = '0;
		prev_port  = '0;
		void'($urandom(32'hca753cf9));
		for (int i = 0; i < `REG_N; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			model_ram[i] = word_t'($urandom());
			u_mem.load_ram(i, model_ram[i]);
		end
		u_mem.fill_rom();
		build_program();

		repeat (16) @(negedge clk);
		reset_n = 1'b1;

		cycles = 0;
		while (!halted && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (halted) begin
			// let the post-halt assertions watch a few more edges
			repeat (5) @(negedge clk);
			assert (exp_wwd.size() == 0) else report_fail("expected WWD values never seen");
			assert (exp_st_addr.size() == 0) else report_fail("expected stores never seen");
			assert (num_inst == word_t'(exp_count))
				else value_fail("num_inst", word_t'(exp_count), num_inst);
			$display("Simulation PASSED");
			$finish;
		end else begin
			report_fail("timeout waiting for halt");
		end
	end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// File: dv/tb_memory.sv
`timescale 1ns/1ns

module tb_memory import cpu_pkg::*; (
	input  logic      clk,
	input  logic      imem_rd_i,
	input  word_t     imem_addr_i,
	output word_t     imem_data_o,
	input  dmem_req_t dmem_req_i,
	output word_t     dmem_rdata_o
);

	localparam int ROM_WORDS = 256;
	localparam int RAM_WORDS = 16;

	word_t rom [ROM_WORDS];
	word_t ram [RAM_WORDS];

	// every word past the program holds its own address pattern
	task automatic fill_rom();
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i] = {i[7:0], ~i[7:0]};
		end
	endtask

	task automatic load_rom(input int addr, input word_t data);
		rom[addr] = data;
	endtask

	task automatic load_ram(input int addr, input word_t data);
		ram[addr] = data;
	endtask

	// same-cycle reads
	assign imem_data_o  = imem_rd_i ? rom[imem_addr_i[7:0]] : '0;
	assign dmem_rdata_o = dmem_req_i.rd ? ram[dmem_req_i.addr[3:0]] : '0;

	// only the low four address bits select a RAM word
	always @(posedge clk) begin
		if (dmem_req_i.wr) begin
			ram[dmem_req_i.addr[3:0]] <= dmem_req_i.wdata;
		end
	end

endmodule

// File: list.f
+incdir+design
design/cpu_pkg.sv
design/pipe_control.sv
design/fetch_stage.sv
design/register_file.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_top.sv
dv/tb_clock.sv
dv/tb_memory.sv
dv/cpu_tb.sv
